//--- verilog/riscvPkg.sv
package riscvPkg;

    typedef logic [31:0] dataWord;
    typedef logic [4:0] regIndex;

    // RV32I major opcodes kept by the core
    typedef enum logic [6:0]
    {
        opcodeLoad   = 7'b0000011,
        opcodeOpImm  = 7'b0010011,
        opcodeAuipc  = 7'b0010111,
        opcodeStore  = 7'b0100011,
        opcodeOp     = 7'b0110011,
        opcodeLui    = 7'b0110111,
        opcodeBranch = 7'b1100011,
        opcodeJalr   = 7'b1100111,
        opcodeJal    = 7'b1101111,
        opcodeSystem = 7'b1110011
    } opcodeKind;

    typedef enum logic [3:0]
    {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOp;

    typedef enum logic [1:0] {srcAPc, srcAOldPc, srcAReg, srcAZero} srcASel;
    typedef enum logic [1:0] {srcBReg, srcBImm, srcBFour} srcBSel;
    typedef enum logic [1:0] {wbResult, wbMemory, wbPc} wbSel;
    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immFormat;

    typedef enum logic [2:0]
    {
        stateReset,
        stateFetch,
        stateDecode,
        stateExecute,
        stateMemory,
        stateWriteBack,
        stateTrapped
    } coreState;

    // ADDI x0, x0, 0
    localparam dataWord nopWord = 32'h0000_0013;

endpackage

//--- verilog/coreCtrlIf.sv
interface coreCtrlIf;
    import riscvPkg::*;

    // Register load enables
    logic pcWrite;
    logic irWrite;
    logic oldPcWrite;
    logic mdrWrite;
    logic resultWrite;
    logic regWrite;

    // Mux selects and ALU control
    srcASel srcA;
    srcBSel srcB;
    aluOp op;
    immFormat format;
    wbSel wbSource;
    logic dataAddress;

    // Status back to the FSM
    dataWord instruction;
    logic branchTaken;

    modport controller
    (
        output pcWrite, irWrite, oldPcWrite, mdrWrite, resultWrite, regWrite,
        output srcA, srcB, op, format, wbSource, dataAddress,
        input  instruction, branchTaken
    );

    modport datapath
    (
        input  pcWrite, irWrite, oldPcWrite, mdrWrite, resultWrite, regWrite,
        input  srcA, srcB, op, format, wbSource, dataAddress,
        output instruction, branchTaken
    );

endinterface

//--- verilog/registerFile.sv
module registerFile
(
    input  logic clk,
    input  logic reset,
    input  riscvPkg::regIndex readIndexA,
    input  riscvPkg::regIndex readIndexB,
    input  riscvPkg::regIndex writeIndex,
    input  logic writeEnable,
    input  riscvPkg::dataWord writeData,
    output riscvPkg::dataWord readDataA,
    output riscvPkg::dataWord readDataB
);
    import riscvPkg::*;

    dataWord registers [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                registers[i] <= '0;
        end
        else if (writeEnable && writeIndex != '0)
            registers[writeIndex] <= writeData;
    end

    assign readDataA = registers[readIndexA];
    assign readDataB = registers[readIndexB];

    assert property (@(posedge clk) disable iff (reset) readIndexA == '0 |-> readDataA == '0);

endmodule

//--- verilog/alu.sv
module alu
(
    input  riscvPkg::aluOp op,
    input  riscvPkg::dataWord operandA,
    input  riscvPkg::dataWord operandB,
    input  logic [2:0] branchFunct,
    output riscvPkg::dataWord result,
    output logic branchTaken
);
    import riscvPkg::*;

    logic [4:0] shiftAmount;
    logic equal;
    logic lessSigned;
    logic lessUnsigned;

    assign shiftAmount = operandB[4:0];
    assign equal = (operandA == operandB);
    assign lessSigned = ($signed(operandA) < $signed(operandB));
    assign lessUnsigned = (operandA < operandB);

    always_comb
    begin
        case (op)
            aluSub: result = operandA - operandB;
            aluSll: result = operandA << shiftAmount;
            aluSlt: result = {31'b0, lessSigned};
            aluSltu: result = {31'b0, lessUnsigned};
            aluXor: result = operandA ^ operandB;
            aluSrl: result = operandA >> shiftAmount;
            aluSra: result = dataWord'($signed(operandA) >>> shiftAmount);
            aluOr: result = operandA | operandB;
            aluAnd: result = operandA & operandB;
            default: result = operandA + operandB;
        endcase
    end

    // funct3 of BEQ, BNE, BLT, BGE, BLTU, BGEU
    always_comb
    begin
        case (branchFunct)
            3'b000: branchTaken = equal;
            3'b001: branchTaken = !equal;
            3'b100: branchTaken = lessSigned;
            3'b101: branchTaken = !lessSigned;
            3'b110: branchTaken = lessUnsigned;
            3'b111: branchTaken = !lessUnsigned;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

//--- verilog/immGen.sv
module immGen
(
    input  riscvPkg::dataWord instruction,
    input  riscvPkg::immFormat format,
    output riscvPkg::dataWord immediate
);
    import riscvPkg::*;

    logic sign;

    assign sign = instruction[31];

    always_comb
    begin
        case (format)
            immS: immediate = {{20{sign}}, instruction[31:25], instruction[11:7]};
            immB: immediate = {{20{sign}}, instruction[7], instruction[30:25],
                               instruction[11:8], 1'b0};
            immU: immediate = {instruction[31:12], 12'b0};
            immJ: immediate = {{12{sign}}, instruction[19:12], instruction[20],
                               instruction[30:21], 1'b0};
            // I format, also the fallback
            default: immediate = {{20{sign}}, instruction[31:20]};
        endcase
    end

endmodule

//--- verilog/controller.sv
module controller
(
    input  logic clk,
    input  logic reset,
    input  logic memReady,
    output logic memEnable,
    output logic memWrite,
    output logic trap,
    coreCtrlIf.controller ctrl
);
    import riscvPkg::*;

    coreState state;
    coreState nextState;
    opcodeKind opcode;
    aluOp decodedOp;
    logic legal;
    logic branchPending;

    //////////////////////////////////////////////////
    // Instruction decode
    //////////////////////////////////////////////////

    assign opcode = opcodeKind'(ctrl.instruction[6:0]);

    always_comb
    begin
        case (opcode)
            opcodeOp, opcodeOpImm, opcodeLoad, opcodeStore, opcodeBranch,
            opcodeJal, opcodeJalr, opcodeLui, opcodeAuipc:
                legal = 1'b1;
            default:
                legal = 1'b0;
        endcase
    end

    // Bit 30 picks SUB and SRA, only SRAI among immediate ops
    always_comb
    begin
        case (ctrl.instruction[14:12])
            3'b000: decodedOp = (opcode == opcodeOp && ctrl.instruction[30]) ? aluSub : aluAdd;
            3'b001: decodedOp = aluSll;
            3'b010: decodedOp = aluSlt;
            3'b011: decodedOp = aluSltu;
            3'b100: decodedOp = aluXor;
            3'b101: decodedOp = ctrl.instruction[30] ? aluSra : aluSrl;
            3'b110: decodedOp = aluOr;
            default: decodedOp = aluAnd;
        endcase
    end

    always_comb
    begin
        case (opcode)
            opcodeStore: ctrl.format = immS;
            opcodeBranch: ctrl.format = immB;
            opcodeLui, opcodeAuipc: ctrl.format = immU;
            opcodeJal: ctrl.format = immJ;
            default: ctrl.format = immI;
        endcase
    end

    //////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= stateReset;
            branchPending <= 1'b0;
        end
        else
        begin
            state <= nextState;
            // Compare result is held until execute needs the ALU for the target
            if (state == stateDecode)
                branchPending <= ctrl.branchTaken;
        end
    end

    assign trap = (state == stateTrapped);

    //////////////////////////////////////////////////
    // Control outputs and next state
    //////////////////////////////////////////////////

    always_comb
    begin
        nextState = state;
        memEnable = 1'b0;
        memWrite = 1'b0;
        ctrl.pcWrite = 1'b0;
        ctrl.irWrite = 1'b0;
        ctrl.oldPcWrite = 1'b0;
        ctrl.mdrWrite = 1'b0;
        ctrl.resultWrite = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.srcA = srcAReg;
        ctrl.srcB = srcBImm;
        ctrl.op = aluAdd;
        ctrl.wbSource = wbResult;
        ctrl.dataAddress = 1'b0;

        case (state)
            stateReset:
                nextState = stateFetch;
            stateFetch:
            begin
                memEnable = 1'b1;
                ctrl.srcA = srcAPc;
                ctrl.srcB = srcBFour;
                if (memReady)
                begin
                    ctrl.irWrite = 1'b1;
                    ctrl.oldPcWrite = 1'b1;
                    ctrl.pcWrite = 1'b1;
                    nextState = stateDecode;
                end
            end
            stateDecode:
            begin
                // Branches compare A with B here, jumps form the link
                ctrl.srcB = srcBReg;
                if (opcode == opcodeJal || opcode == opcodeJalr)
                begin
                    ctrl.srcA = srcAOldPc;
                    ctrl.srcB = srcBFour;
                    ctrl.resultWrite = 1'b1;
                end
                nextState = legal ? stateExecute : stateTrapped;
            end
            stateExecute:
            begin
                ctrl.resultWrite = 1'b1;
                nextState = stateWriteBack;
                case (opcode)
                    opcodeOp:
                    begin
                        ctrl.srcB = srcBReg;
                        ctrl.op = decodedOp;
                    end
                    opcodeOpImm:
                        ctrl.op = decodedOp;
                    opcodeLui:
                        ctrl.srcA = srcAZero;
                    opcodeAuipc:
                        ctrl.srcA = srcAOldPc;
                    opcodeLoad, opcodeStore:
                        nextState = stateMemory;
                    opcodeBranch:
                    begin
                        ctrl.srcA = srcAOldPc;
                        ctrl.resultWrite = 1'b0;
                        ctrl.pcWrite = branchPending;
                        nextState = stateFetch;
                    end
                    default:
                    begin
                        // JAL or JALR, link stays in the result register
                        if (opcode == opcodeJal)
                            ctrl.srcA = srcAOldPc;
                        ctrl.resultWrite = 1'b0;
                        ctrl.pcWrite = 1'b1;
                    end
                endcase
            end
            stateMemory:
            begin
                memEnable = 1'b1;
                memWrite = (opcode == opcodeStore);
                ctrl.dataAddress = 1'b1;
                if (memReady)
                begin
                    ctrl.mdrWrite = (opcode == opcodeLoad);
                    nextState = (opcode == opcodeLoad) ? stateWriteBack : stateFetch;
                end
            end
            stateWriteBack:
            begin
                ctrl.regWrite = 1'b1;
                if (opcode == opcodeLoad)
                    ctrl.wbSource = wbMemory;
                nextState = stateFetch;
            end
            default:
                nextState = stateTrapped;
        endcase
    end

    // Trap holds and the bus stays quiet until reset
    assert property (@(posedge clk) disable iff (reset) trap |=> trap && !memEnable);
    assert property (@(posedge clk) disable iff (reset) memWrite |-> memEnable);

endmodule

//--- verilog/datapath.sv
module datapath
#(
    parameter riscvPkg::dataWord resetAddress = '0
)
(
    input  logic clk,
    input  logic reset,
    output riscvPkg::dataWord memAddress,
    output riscvPkg::dataWord memWriteData,
    input  riscvPkg::dataWord memReadData,
    coreCtrlIf.datapath ctrl
);
    import riscvPkg::*;

    dataWord pc;
    dataWord oldPc;
    dataWord ir;
    dataWord mdr;
    dataWord regA;
    dataWord regB;
    dataWord result;
    dataWord immediate;
    dataWord aluA;
    dataWord aluB;
    dataWord aluResult;
    dataWord readDataA;
    dataWord readDataB;
    dataWord writeData;
    regIndex readIndexA;
    regIndex readIndexB;

    //////////////////////////////////////////////////
    // Architectural registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= resetAddress;
            ir <= nopWord;
        end
        else
        begin
            // Bit 0 dropped for JALR targets
            if (ctrl.pcWrite)
                pc <= {aluResult[31:1], 1'b0};
            if (ctrl.irWrite)
                ir <= memReadData;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.oldPcWrite)
            oldPc <= pc;
        if (ctrl.mdrWrite)
            mdr <= memReadData;
        if (ctrl.resultWrite)
            result <= aluResult;
        regA <= readDataA;
        regB <= readDataB;
    end

    // Operands follow the incoming word so A and B are valid in decode
    assign readIndexA = ctrl.irWrite ? memReadData[19:15] : ir[19:15];
    assign readIndexB = ctrl.irWrite ? memReadData[24:20] : ir[24:20];

    registerFile regs
    (
        .clk(clk),
        .reset(reset),
        .readIndexA(readIndexA),
        .readIndexB(readIndexB),
        .writeIndex(ir[11:7]),
        .writeEnable(ctrl.regWrite),
        .writeData(writeData),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    immGen immediates
    (
        .instruction(ir),
        .format(ctrl.format),
        .immediate(immediate)
    );

    //////////////////////////////////////////////////
    // Operand and write-back muxes
    //////////////////////////////////////////////////

    always_comb
    begin
        case (ctrl.srcA)
            srcAPc: aluA = pc;
            srcAOldPc: aluA = oldPc;
            srcAReg: aluA = regA;
            default: aluA = '0;
        endcase

        case (ctrl.srcB)
            srcBReg: aluB = regB;
            srcBImm: aluB = immediate;
            default: aluB = 32'd4;
        endcase

        case (ctrl.wbSource)
            wbMemory: writeData = mdr;
            wbPc: writeData = pc;
            default: writeData = result;
        endcase
    end

    alu arith
    (
        .op(ctrl.op),
        .operandA(aluA),
        .operandB(aluB),
        .branchFunct(ir[14:12]),
        .result(aluResult),
        .branchTaken(ctrl.branchTaken)
    );

    assign ctrl.instruction = ir;
    assign memAddress = ctrl.dataAddress ? result : pc;
    assign memWriteData = regB;

    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- verilog/riscvCore.sv
module riscvCore
#(
    parameter riscvPkg::dataWord resetAddress = '0
)
(
    input  logic clk,
    input  logic reset,
    output logic trap,
    output logic memEnable,
    output logic memWrite,
    output riscvPkg::dataWord memAddress,
    output riscvPkg::dataWord memWriteData,
    input  riscvPkg::dataWord memReadData,
    input  logic memReady
);

    coreCtrlIf ctrlBus ();

    controller controlUnit
    (
        .clk(clk),
        .reset(reset),
        .memReady(memReady),
        .memEnable(memEnable),
        .memWrite(memWrite),
        .trap(trap),
        .ctrl(ctrlBus.controller)
    );

    datapath #(.resetAddress(resetAddress)) dataUnit
    (
        .clk(clk),
        .reset(reset),
        .memAddress(memAddress),
        .memWriteData(memWriteData),
        .memReadData(memReadData),
        .ctrl(ctrlBus.datapath)
    );

endmodule

//--- tests/tbTests.svh
//////////////////////////////////////////////////
// RV32I encoders
//////////////////////////////////////////////////

function automatic dataWord encR(logic [6:0] f7, regIndex rs2, regIndex rs1,
                                 logic [2:0] f3, regIndex rd);
    return {f7, rs2, rs1, f3, rd, opcodeOp};
endfunction

function automatic dataWord encI(logic [11:0] imm, regIndex rs1, logic [2:0] f3,
                                 regIndex rd, opcodeKind opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic dataWord encS(logic [11:0] imm, regIndex rs2, regIndex rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcodeStore};
endfunction

function automatic dataWord encB(logic [12:0] imm, regIndex rs2, regIndex rs1,
                                 logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcodeBranch};
endfunction

function automatic dataWord encU(logic [19:0] imm, regIndex rd, opcodeKind opc);
    return {imm, rd, opc};
endfunction

function automatic dataWord encJ(logic [20:0] imm, regIndex rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcodeJal};
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic checkWord(input dataWord actual, input dataWord expected, input string what);
    if (actual !== expected)
    begin
        $display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
        $display("Finished with errors");
        $fatal(1, "Word mismatch");
    end
endtask

task automatic checkFlag(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
        $display("Error at time %0t: %s is %b, expected %b", $time, what, actual, expected);
        $display("Finished with errors");
        $fatal(1, "Flag mismatch");
    end
endtask

task automatic checkState(input coreState actual, input coreState expected, input string what);
    if (actual !== expected)
    begin
        $display("Error at time %0t: %s is %s, expected %s", $time, what,
                 actual.name(), expected.name());
        $display("Finished with errors");
        $fatal(1, "State mismatch");
    end
endtask

//////////////////////////////////////////////////
// Program building and running
//////////////////////////////////////////////////

// Program in the low half and an address pattern in the data half
task automatic clearProgram();
    for (int i = 0; i < 256; i++)
        mem[i[7:0]] = (i < 128) ? nopWord : {16'hDA7A, 6'b0, i[7:0], 2'b00};
    progIndex = bootAddress[9:2];
    slot = 12'h200;
    expAddr.delete();
    expData.delete();
    storeAddr.delete();
    storeData.delete();
endtask

function automatic dataWord pcNow();
    return {22'b0, progIndex, 2'b00};
endfunction

task automatic emit(input dataWord word);
    mem[progIndex] = word;
    progIndex = progIndex + 8'd1;
endtask

task automatic emitEcall();
    emit(encI(12'h000, 5'd0, 3'b000, 5'd0, opcodeSystem));
endtask

task automatic loadConst(input regIndex rd, input dataWord value);
    dataWord upper;
    // ADDI sign-extends, so round the upper part
    upper = value + 32'h800;
    emit(encU(upper[31:12], rd, opcodeLui));
    emit(encI(value[11:0], rd, 3'b000, rd, opcodeOpImm));
endtask

task automatic storeAt(input regIndex rs);
    emit(encS(slot, rs, 5'd0));
endtask

task automatic expectSlot(input dataWord expected);
    expAddr.push_back({20'b0, slot});
    expData.push_back(expected);
    slot = slot + 12'd4;
endtask

task automatic storeReg(input regIndex rs, input dataWord expected);
    storeAt(rs);
    expectSlot(expected);
endtask

task automatic pulseReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
endtask

task automatic waitTrap(input int limit);
    int cycles;
    cycles = 0;
    while (trap !== 1'b1 && cycles < limit)
    begin
        @(negedge clk);
        cycles++;
    end
    if (trap !== 1'b1)
    begin
        $display("Timeout: the core did not raise trap within %0d cycles", limit);
        $display("Finished with errors");
        $fatal(1, "Trap wait expired");
    end
endtask

task automatic verifyStores();
    checkWord(dataWord'(storeAddr.size()), dataWord'(expAddr.size()), "number of stores");
    foreach (expAddr[i])
    begin
        checkWord(storeAddr[i], expAddr[i], $sformatf("address of store %0d", i));
        checkWord(storeData[i], expData[i], $sformatf("data of store %0d", i));
    end
endtask

task automatic runProgram();
    emitEcall();
    pulseReset();
    waitTrap(4000);
    verifyStores();
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic bootTest();
    clearProgram();
    storeReg(5'd0, 32'h0);
    emitEcall();
    pulseReset();
    // One idle cycle in the reset state
    @(negedge clk);
    checkState(u_dut.controlUnit.state, stateReset, "state after reset");
    checkFlag(memEnable, 1'b0, "memEnable after reset");
    checkFlag(memWrite, 1'b0, "memWrite after reset");
    checkFlag(trap, 1'b0, "trap after reset");
    @(negedge clk);
    checkFlag(memEnable, 1'b1, "memEnable of first fetch");
    checkFlag(memWrite, 1'b0, "memWrite of first fetch");
    checkWord(memAddress, bootAddress, "first fetch address");
    waitTrap(4000);
    for (int i = 0; i < 20; i++)
    begin
        @(negedge clk);
        checkFlag(memEnable, 1'b0, "memEnable while trapped");
        checkFlag(trap, 1'b1, "trap while trapped");
    end
    verifyStores();
endtask

task automatic regOpCase(input logic [6:0] f7, input logic [2:0] f3, input dataWord expected);
    emit(encR(f7, 5'd2, 5'd1, f3, 5'd3));
    storeReg(5'd3, expected);
endtask

task automatic immOpCase(input logic [11:0] imm, input logic [2:0] f3,
                         input dataWord expected);
    emit(encI(imm, 5'd1, f3, 5'd3, opcodeOpImm));
    storeReg(5'd3, expected);
endtask

task automatic aluTest();
    dataWord a;
    dataWord b;
    a = 32'hFFED_2979;
    b = 32'h0000_0015;
    clearProgram();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    regOpCase(7'h00, 3'b000, a + b);
    regOpCase(7'h20, 3'b000, a - b);
    regOpCase(7'h00, 3'b001, a << b[4:0]);
    regOpCase(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
    regOpCase(7'h00, 3'b011, {31'b0, a < b});
    regOpCase(7'h00, 3'b100, a ^ b);
    regOpCase(7'h00, 3'b101, a >> b[4:0]);
    // a is negative, so SRA shifts in ones
    regOpCase(7'h20, 3'b101, ~(~a >> b[4:0]));
    regOpCase(7'h00, 3'b110, a | b);
    regOpCase(7'h00, 3'b111, a & b);
    // Immediates are sign-extended from 12 bits
    immOpCase(12'hFB3, 3'b000, a + 32'hFFFF_FFB3);
    immOpCase(12'hFFB, 3'b010, {31'b0, $signed(a) < $signed(32'hFFFF_FFFB)});
    immOpCase(12'hFFB, 3'b011, {31'b0, a < 32'hFFFF_FFFB});
    immOpCase(12'h5A5, 3'b100, a ^ 32'h0000_05A5);
    immOpCase(12'hF00, 3'b110, a | 32'hFFFF_FF00);
    immOpCase(12'h7F0, 3'b111, a & 32'h0000_07F0);
    immOpCase(12'd17, 3'b001, a << 17);
    immOpCase(12'd23, 3'b101, a >> 23);
    immOpCase(12'h414, 3'b101, ~(~a >> 20));
    runProgram();
endtask

// Taken path skips the fall-through marker and the jump over the taken marker
task automatic branchCase(input logic [2:0] f3, input regIndex rs1, input regIndex rs2,
                          input logic taken);
    emit(encB(13'd12, rs2, rs1, f3));
    storeAt(5'd5);
    emit(encJ(21'd8, 5'd0));
    storeAt(5'd6);
    expectSlot(taken ? markTaken : markFall);
endtask

task automatic branchTest();
    clearProgram();
    // x1 is -5 and x2 is 3
    loadConst(5'd1, 32'hFFFF_FFFB);
    loadConst(5'd2, 32'h0000_0003);
    loadConst(5'd5, markFall);
    loadConst(5'd6, markTaken);
    branchCase(3'b000, 5'd1, 5'd1, 1'b1);
    branchCase(3'b000, 5'd1, 5'd2, 1'b0);
    branchCase(3'b001, 5'd1, 5'd2, 1'b1);
    branchCase(3'b001, 5'd1, 5'd1, 1'b0);
    branchCase(3'b100, 5'd1, 5'd2, 1'b1);
    branchCase(3'b100, 5'd2, 5'd1, 1'b0);
    branchCase(3'b101, 5'd2, 5'd1, 1'b1);
    branchCase(3'b101, 5'd1, 5'd2, 1'b0);
    branchCase(3'b110, 5'd2, 5'd1, 1'b1);
    branchCase(3'b110, 5'd1, 5'd2, 1'b0);
    branchCase(3'b111, 5'd1, 5'd2, 1'b1);
    branchCase(3'b111, 5'd2, 5'd1, 1'b0);
    runProgram();
endtask

task automatic jumpTest();
    dataWord origin;
    dataWord target;
    clearProgram();
    loadConst(5'd5, markFall);
    loadConst(5'd6, markTaken);
    origin = pcNow();
    emit(encJ(21'd8, 5'd7));
    storeAt(5'd5);
    storeReg(5'd7, origin + 32'd4);
    storeReg(5'd6, markTaken);
    // JALR with an odd offset lands on the even target
    origin = pcNow();
    target = origin + 32'd12;
    emit(encI(target[11:0], 5'd0, 3'b000, 5'd8, opcodeOpImm));
    emit(encI(12'd1, 5'd8, 3'b000, 5'd9, opcodeJalr));
    storeAt(5'd5);
    storeReg(5'd9, origin + 32'd8);
    storeReg(5'd6, markTaken);
    runProgram();
endtask

task automatic upperTest();
    dataWord origin;
    clearProgram();
    emit(encU(20'hABCDE, 5'd10, opcodeLui));
    storeReg(5'd10, 32'hABCD_E000);
    origin = pcNow();
    emit(encU(20'h12345, 5'd11, opcodeAuipc));
    storeReg(5'd11, origin + 32'h1234_5000);
    runProgram();
endtask

task automatic loadStoreTest();
    dataWord value;
    logic [11:0] loadSlot;
    value = 32'h5EED_C0DE;
    clearProgram();
    loadConst(5'd12, value);
    loadSlot = slot;
    storeReg(5'd12, value);
    emit(encI(loadSlot, 5'd0, 3'b010, 5'd13, opcodeLoad));
    storeReg(5'd13, value);
    // Writes to x0 by ALU and load are both dropped
    emit(encI(12'd123, 5'd0, 3'b000, 5'd0, opcodeOpImm));
    emit(encI(loadSlot, 5'd0, 3'b010, 5'd0, opcodeLoad));
    storeReg(5'd0, 32'h0);
    runProgram();
endtask

//--- tests/tbCore.sv
module tbCore;
    import riscvPkg::*;

    localparam dataWord bootAddress = 32'h0000_0040;
    localparam dataWord markFall = 32'h1111_1111;
    localparam dataWord markTaken = 32'h2222_2222;

    logic clk;
    logic reset;
    logic trap;
    logic memEnable;
    logic memWrite;
    dataWord memAddress;
    dataWord memWriteData;
    dataWord memReadData = '0;
    logic memReady = 1'b0;

    // Memory model state
    dataWord mem [256];
    integer seed = 32'h413bf0a0;
    int waitLeft;
    logic busy;
    dataWord storeAddr [$];
    dataWord storeData [$];

    // Program being assembled and the stores it should make
    logic [7:0] progIndex;
    logic [11:0] slot;
    dataWord expAddr [$];
    dataWord expData [$];

    riscvCore #(.resetAddress(bootAddress)) u_dut
    (
        .clk(clk),
        .reset(reset),
        .trap(trap),
        .memEnable(memEnable),
        .memWrite(memWrite),
        .memAddress(memAddress),
        .memWriteData(memWriteData),
        .memReadData(memReadData),
        .memReady(memReady)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Memory with 0 to 3 wait cycles per transfer
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (reset)
        begin
            memReady <= 1'b0;
            busy = 1'b0;
        end
        else if (memReady)
        begin
            // Transfer completes on this edge
            memReady <= 1'b0;
            busy = 1'b0;
            if (memWrite)
            begin
                mem[memAddress[9:2]] = memWriteData;
                storeAddr.push_back(memAddress);
                storeData.push_back(memWriteData);
            end
        end
        else if (memEnable)
        begin
            if (!busy)
            begin
                busy = 1'b1;
                waitLeft = $random(seed) & 3;
            end
            if (waitLeft == 0)
            begin
                memReady <= 1'b1;
                memReadData <= mem[memAddress[9:2]];
            end
            else
                waitLeft = waitLeft - 1;
        end
    end

    `include "tbTests.svh"

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial
    begin
        reset <= 1'b1;
        // Core parks in trap until the first test
        clearProgram();
        emitEcall();
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        bootTest();
        aluTest();
        branchTest();
        jumpTest();
        upperTest();
        loadStoreTest();

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- all.f
+incdir+tests
verilog/riscvPkg.sv
verilog/coreCtrlIf.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/immGen.sv
verilog/controller.sv
verilog/datapath.sv
verilog/riscvCore.sv
tests/tbCore.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert --timing -j 0 --top-module tbCore -f all.f > build.log 2>&1 &&
    ./obj_dir/VtbCore > sim.log 2>&1
grep -qx "Finished with no errors" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }
